/* source/mask_unit_pkg.sv */
// shared widths, encodings and pipeline structs of the vector mask unit; compile before any rtl
package mask_unit_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////
    localparam int VLEN      = 256;        // bits in one vector register
    localparam int MASK_BITS = VLEN / 8;   // one mask bit per sew8 element
    localparam int IDX_W     = 6;          // vl / vstart range 0..MASK_BITS

    ////////////////////////////////////////
    // encodings
    ////////////////////////////////////////
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } vsew_e;                              // standard vsew field

    typedef enum logic [2:0] {
        MOP_AND  = 3'd0,                   // vmand.mm
        MOP_NAND = 3'd1,                   // vmnand.mm
        MOP_ANDN = 3'd2,                   // vmandn.mm
        MOP_XOR  = 3'd3,                   // vmxor.mm
        MOP_OR   = 3'd4,                   // vmor.mm
        MOP_NOR  = 3'd5,                   // vmnor.mm
        MOP_ORN  = 3'd6,                   // vmorn.mm
        MOP_XNOR = 3'd7                    // vmxnor.mm
    } mask_op_e;

    typedef enum logic [1:0] {
        ACT_KEEP = 2'd0,                   // old destination element
        ACT_NEW  = 2'd1,                   // lane result
        ACT_ONES = 2'd2                    // agnostic fill
    } elem_act_e;

    ////////////////////////////////////////
    // data and stage types
    ////////////////////////////////////////
    // one register word, read as elements of whichever sew is active
    typedef union packed {
        logic [VLEN/8-1:0][7:0]   e8;
        logic [VLEN/16-1:0][15:0] e16;
        logic [VLEN/32-1:0][31:0] e32;
        logic [VLEN/64-1:0][63:0] e64;
    } vreg_u;

    typedef struct packed {
        vsew_e            vsew;            // element width
        logic [IDX_W-1:0] vl;              // active length
        logic [IDX_W-1:0] vstart;          // first body element
        logic             vta;             // tail agnostic
        logic             vma;             // mask agnostic
        logic             mask_en;         // low = bypass
    } vcfg_t;

    typedef struct packed {
        vsew_e                     vsew;     // view used by the merge
        elem_act_e [MASK_BITS-1:0] act;      // per-slot action, slot 0 in lsbs
        vreg_u                     new_data; // lanes result
        vreg_u                     old_data; // destination contents
    } merge_cmd_t;

    // element count of one register at the given sew
    function automatic logic [IDX_W-1:0] vlmax_of(vsew_e vsew);
        return IDX_W'(VLEN / (8 << int'(vsew)));
    endfunction

endpackage

/* source/element_classifier.sv */
// stage 1 of the mask unit pipeline; classifies each element slot and registers the merge command
`timescale 1ns/1ps

module element_classifier (
    input  logic                                clk,
    input  logic                                reset,
    input  mask_unit_pkg::vcfg_t                cfg,              // sew, vl, vstart, policy
    input  mask_unit_pkg::vreg_u                lanes_data_out,   // lane results
    input  mask_unit_pkg::vreg_u                destination_data, // old vd contents
    input  logic [mask_unit_pkg::MASK_BITS-1:0] v0,               // element mask
    output mask_unit_pkg::merge_cmd_t           cmd               // to element_merge
);

    import mask_unit_pkg::*;

    elem_act_e [MASK_BITS-1:0] act;     // next-cycle actions

    ////////////////////////////////////////
    // per-slot classification
    ////////////////////////////////////////
    always_comb begin
        logic [IDX_W-1:0] idx;          // slot number at vl width
        logic             prestart;
        logic             body;

        idx      = '0;
        prestart = 1'b0;
        body     = 1'b0;
        for (int i = 0; i < MASK_BITS; i++) begin
            idx      = IDX_W'(i);
            prestart = idx < cfg.vstart;                     // i < vstart
            body     = !prestart && (idx < cfg.vl);          // vstart <= i < vl

            if (!cfg.mask_en) begin
                act[i] = ACT_NEW;                            // bypass, every slot
            end else if (prestart) begin
                act[i] = ACT_KEEP;
            end else if (body) begin
                if (v0[i]) begin
                    act[i] = ACT_NEW;                        // active element
                end else begin
                    act[i] = cfg.vma ? ACT_ONES : ACT_KEEP;  // masked off
                end
            end else begin
                act[i] = cfg.vta ? ACT_ONES : ACT_KEEP;      // tail, i >= vl
            end
        end
    end

    ////////////////////////////////////////
    // stage register
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            cmd <= '0;                              // pipeline reads zero after reset
        end else begin
            cmd.vsew     <= cfg.vsew;
            cmd.act      <= act;
            cmd.new_data <= lanes_data_out;
            cmd.old_data <= destination_data;
        end
    end

    ////////////////////////////////////////
    // request range checks
    ////////////////////////////////////////
    // prestart region may not run past the active length
    vstart_le_vl_a: assert property (
        @(posedge clk) disable iff (reset)
        cfg.vstart <= cfg.vl
    ) else $error("vstart %0d above vl %0d", cfg.vstart, cfg.vl);

    // vl may not exceed the element count of one register at this sew
    vl_le_vlmax_a: assert property (
        @(posedge clk) disable iff (reset)
        cfg.vl <= vlmax_of(cfg.vsew)
    ) else $error("vl %0d above vlmax %0d", cfg.vl, vlmax_of(cfg.vsew));

endmodule

/* source/element_merge.sv */
// stage 2 of the mask unit pipeline; builds each destination element at the active sew
`timescale 1ns/1ps

module element_merge (
    input  logic                      clk,
    input  logic                      reset,
    input  mask_unit_pkg::merge_cmd_t cmd,              // from element_classifier
    output mask_unit_pkg::vreg_u      mask_unit_output  // merged vd word
);

    import mask_unit_pkg::*;

    vreg_u merged;                      // combinational result

    // element select, widest case; callers truncate to their sew
    function automatic logic [63:0] pick(
        input elem_act_e   act,
        input logic [63:0] old_e,
        input logic [63:0] new_e
    );
        case (act)
            ACT_NEW:  return new_e;
            ACT_ONES: return '1;                 // all ones at any width
            default:  return old_e;              // keep, unused code too
        endcase
    endfunction

    ////////////////////////////////////////
    // merge at the selected view
    ////////////////////////////////////////
    // slot i maps to element i, slots past vlmax left untouched
    always_comb begin
        merged = cmd.old_data;
        case (cmd.vsew)
            SEW_8: begin
                for (int i = 0; i < VLEN / 8; i++) begin
                    merged.e8[i] = 8'(pick(cmd.act[i],
                                           64'(cmd.old_data.e8[i]),
                                           64'(cmd.new_data.e8[i])));
                end
            end
            SEW_16: begin
                for (int i = 0; i < VLEN / 16; i++) begin
                    merged.e16[i] = 16'(pick(cmd.act[i],
                                             64'(cmd.old_data.e16[i]),
                                             64'(cmd.new_data.e16[i])));
                end
            end
            SEW_32: begin
                for (int i = 0; i < VLEN / 32; i++) begin
                    merged.e32[i] = 32'(pick(cmd.act[i],
                                             64'(cmd.old_data.e32[i]),
                                             64'(cmd.new_data.e32[i])));
                end
            end
            default: begin                       // SEW_64
                for (int i = 0; i < VLEN / 64; i++) begin
                    merged.e64[i] = pick(cmd.act[i],
                                         cmd.old_data.e64[i],
                                         cmd.new_data.e64[i]);
                end
            end
        endcase
    end

    ////////////////////////////////////////
    // output register
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            mask_unit_output <= '0;              // zero until first request lands
        end else begin
            mask_unit_output <= merged;
        end
    end

endmodule

/* source/mask_logic_unit.sv */
// mask-register logical ops (vmand..vmxnor), two register stages to track the data path
`timescale 1ns/1ps

module mask_logic_unit (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [mask_unit_pkg::MASK_BITS-1:0] vs1,              // vs1.mask
    input  logic [mask_unit_pkg::MASK_BITS-1:0] vs2,              // vs2.mask
    input  mask_unit_pkg::mask_op_e             mask_op,          // function select
    output logic [mask_unit_pkg::MASK_BITS-1:0] mask_reg_updated  // result
);

    import mask_unit_pkg::*;

    typedef struct packed {
        logic [MASK_BITS-1:0] vs1;
        logic [MASK_BITS-1:0] vs2;
        mask_op_e             op;
    } mlu_opnd_t;                       // stage 1 operand bundle

    mlu_opnd_t            opnd_q;       // registered operands
    logic [MASK_BITS-1:0] result;       // stage 2 input

    // stage 1, capture operands
    always_ff @(posedge clk) begin
        if (reset) begin
            opnd_q <= '0;
        end else begin
            opnd_q <= '{vs1: vs1, vs2: vs2, op: mask_op};
        end
    end

    always_comb begin
        case (opnd_q.op)
            MOP_AND:  result = opnd_q.vs2 & opnd_q.vs1;
            MOP_NAND: result = ~(opnd_q.vs2 & opnd_q.vs1);
            MOP_ANDN: result = opnd_q.vs2 & ~opnd_q.vs1;   // vs1 inverted
            MOP_XOR:  result = opnd_q.vs2 ^ opnd_q.vs1;
            MOP_OR:   result = opnd_q.vs2 | opnd_q.vs1;
            MOP_NOR:  result = ~(opnd_q.vs2 | opnd_q.vs1);
            MOP_ORN:  result = opnd_q.vs2 | ~opnd_q.vs1;   // vs1 inverted
            default:  result = ~(opnd_q.vs2 ^ opnd_q.vs1); // xnor
        endcase
    end

    // stage 2, result register
    always_ff @(posedge clk) begin
        if (reset) begin
            mask_reg_updated <= '0;
        end else begin
            mask_reg_updated <= result;
        end
    end

endmodule

/* source/vector_mask_unit.sv */
// top of the pipelined vector mask unit; element merge and mask-op paths, 2-cycle latency
`timescale 1ns/1ps

module vector_mask_unit (
    input  logic                                clk,
    input  logic                                reset,
    input  mask_unit_pkg::vcfg_t                cfg,              // vsew, vl, vstart, vta, vma
    input  mask_unit_pkg::vreg_u                lanes_data_out,   // lane results
    input  mask_unit_pkg::vreg_u                destination_data, // current vd
    input  logic [mask_unit_pkg::MASK_BITS-1:0] v0,               // mask register
    input  logic [mask_unit_pkg::MASK_BITS-1:0] vs1,
    input  logic [mask_unit_pkg::MASK_BITS-1:0] vs2,
    input  mask_unit_pkg::mask_op_e             mask_op,
    output mask_unit_pkg::vreg_u                mask_unit_output, // merged vd
    output logic [mask_unit_pkg::MASK_BITS-1:0] mask_reg_updated  // mask op result
);

    import mask_unit_pkg::*;

    merge_cmd_t cmd;                    // stage 1 -> stage 2

    element_classifier class_i (
        .clk              (clk),
        .reset            (reset),
        .cfg              (cfg),
        .lanes_data_out   (lanes_data_out),
        .destination_data (destination_data),
        .v0               (v0),
        .cmd              (cmd)
    );

    element_merge merge_i (
        .clk              (clk),
        .reset            (reset),
        .cmd              (cmd),
        .mask_unit_output (mask_unit_output)
    );

    // runs beside the data path, same latency
    mask_logic_unit mlu_i (
        .clk              (clk),
        .reset            (reset),
        .vs1              (vs1),
        .vs2              (vs2),
        .mask_op          (mask_op),
        .mask_reg_updated (mask_reg_updated)
    );

    // bypass through both stages, lanes word back out two edges later
    bypass_latency_a: assert property (
        @(posedge clk) disable iff (reset)
        !cfg.mask_en |-> ##2 (mask_unit_output == $past(lanes_data_out, 2))
    ) else $error("bypass result does not match lanes data from two cycles back");

endmodule

/* verif/mask_unit_model.svh */
// reference model of both mask unit outputs; included inside the testbench module body
`ifndef MASK_UNIT_MODEL_SVH
`define MASK_UNIT_MODEL_SVH

// expected vd word for one request, element rules of the rvv spec
function automatic vreg_u model_merge(
    input vcfg_t                cfg,
    input vreg_u                lanes,
    input vreg_u                dest,
    input logic [MASK_BITS-1:0] v0
);
    logic [VLEN-1:0] lane_bits;       // flat copies of both words
    logic [VLEN-1:0] res;
    int              ew;              // element width in bits
    int              nelem;           // elements at this sew
    logic            take_new;
    logic            fill;

    lane_bits = lanes;
    res       = dest;                 // prestart and undisturbed elements
    ew        = 8 << int'(cfg.vsew);
    nelem     = VLEN / ew;
    for (int i = 0; i < nelem; i++) begin
        take_new = 1'b0;
        fill     = 1'b0;
        if (!cfg.mask_en) begin
            take_new = 1'b1;          // bypass
        end else if (i >= int'(cfg.vl)) begin
            fill = cfg.vta;           // tail
        end else if (i >= int'(cfg.vstart)) begin
            if (v0[i]) begin
                take_new = 1'b1;      // active body element
            end else begin
                fill = cfg.vma;       // inactive body element
            end
        end
        for (int b = 0; b < ew; b++) begin
            if (take_new) begin
                res[i*ew+b] = lane_bits[i*ew+b];
            end else if (fill) begin
                res[i*ew+b] = 1'b1;
            end
        end
    end
    return res;
endfunction

// mask-register op as a per-bit truth table, index {vs2, vs1}
function automatic logic [MASK_BITS-1:0] model_mask_op(
    input mask_op_e             op,
    input logic [MASK_BITS-1:0] vs1,
    input logic [MASK_BITS-1:0] vs2
);
    logic [3:0]           tt;         // outputs for 11, 10, 01, 00
    logic [MASK_BITS-1:0] res;

    tt = 4'b0000;
    case (op)
        MOP_AND:  tt = 4'b1000;
        MOP_NAND: tt = 4'b0111;
        MOP_ANDN: tt = 4'b0100;       // vs2 and not vs1
        MOP_XOR:  tt = 4'b0110;
        MOP_OR:   tt = 4'b1110;
        MOP_NOR:  tt = 4'b0001;
        MOP_ORN:  tt = 4'b1101;       // vs2 or not vs1
        MOP_XNOR: tt = 4'b1001;
    endcase
    for (int b = 0; b < MASK_BITS; b++) begin
        res[b] = tt[{vs2[b], vs1[b]}];
    end
    return res;
endfunction

`endif

/* verif/tb_vector_mask_unit.sv */
// random-stimulus testbench for vector_mask_unit; compares both outputs with the included model
`timescale 1ns/1ps

module tb_vector_mask_unit;

    import mask_unit_pkg::*;

    `include "mask_unit_model.svh"

    localparam int NUM_REQ    = 2000;   // random requests
    localparam int LATENCY    = 2;      // input edge to output, in cycles
    localparam int WAIT_LIMIT = 20;     // cycles allowed for any wait

    typedef struct packed {
        vreg_u                data;     // expected mask_unit_output
        logic [MASK_BITS-1:0] mask;     // expected mask_reg_updated
    } expect_t;

    logic                 clk;
    logic                 reset;
    vcfg_t                cfg;
    vreg_u                lanes_data_out;
    vreg_u                destination_data;
    logic [MASK_BITS-1:0] v0;
    logic [MASK_BITS-1:0] vs1;
    logic [MASK_BITS-1:0] vs2;
    mask_op_e             mask_op;
    vreg_u                mask_unit_output;
    logic [MASK_BITS-1:0] mask_reg_updated;

    expect_t exp_q[$];                  // one entry per cycle in flight
    integer  seed;
    int      results_seen;

    vector_mask_unit dut_i (
        .clk              (clk),
        .reset            (reset),
        .cfg              (cfg),
        .lanes_data_out   (lanes_data_out),
        .destination_data (destination_data),
        .v0               (v0),
        .vs1              (vs1),
        .vs2              (vs2),
        .mask_op          (mask_op),
        .mask_unit_output (mask_unit_output),
        .mask_reg_updated (mask_reg_updated)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;         // 40 ns period
    end

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////
    function automatic vreg_u rand_word();
        logic [VLEN-1:0] w;

        for (int k = 0; k < VLEN / 32; k++) begin
            w[k*32 +: 32] = $random(seed);
        end
        return w;
    endfunction

    task automatic drive_idle();
        cfg              = '0;          // vl = vstart = 0, bypass
        lanes_data_out   = '0;
        destination_data = '0;
        v0               = '0;
        vs1              = '0;
        vs2              = '0;
        mask_op          = MOP_AND;
    endtask

    // one legal random request, expected result queued behind it
    task automatic drive_random();
        logic [31:0]      r;
        logic [IDX_W-1:0] vlmax;
        expect_t          exp_e;

        r           = $random(seed);
        cfg.vsew    = vsew_e'(r[1:0]);
        cfg.vta     = r[2];
        cfg.vma     = r[3];
        cfg.mask_en = (r[5:4] != 2'b00);    // bypass about one in four
        mask_op     = mask_op_e'(r[8:6]);
        vlmax       = vlmax_of(cfg.vsew);
        case (r[11:9])
            3'd0: begin                     // empty body
                cfg.vl     = '0;
                cfg.vstart = '0;
            end
            3'd1: begin                     // full length, no tail
                r          = $random(seed);
                cfg.vl     = vlmax;
                cfg.vstart = IDX_W'(r[31:16] % (16'(cfg.vl) + 16'd1));
            end
            3'd2: begin                     // no prestart
                r          = $random(seed);
                cfg.vl     = IDX_W'(r[15:0] % (16'(vlmax) + 16'd1));
                cfg.vstart = '0;
            end
            default: begin
                r          = $random(seed);
                cfg.vl     = IDX_W'(r[15:0] % (16'(vlmax) + 16'd1));
                cfg.vstart = IDX_W'(r[31:16] % (16'(cfg.vl) + 16'd1));
            end
        endcase
        lanes_data_out   = rand_word();
        destination_data = rand_word();
        v0               = $random(seed);
        vs1              = $random(seed);
        vs2              = $random(seed);

        exp_e.data = model_merge(cfg, lanes_data_out, destination_data, v0);
        exp_e.mask = model_mask_op(mask_op, vs1, vs2);
        exp_q.push_back(exp_e);
    endtask

    ////////////////////////////////////////
    // checking
    ////////////////////////////////////////
    task automatic check_value(
        input string           what,
        input logic [VLEN-1:0] actual,
        input logic [VLEN-1:0] expected
    );
        if (actual !== expected) begin
            $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Verification failed");
            $fatal(1, "%s mismatch", what);
        end
    endtask

    task automatic check_outputs();
        expect_t exp_e;

        exp_e = exp_q.pop_front();      // queued LATENCY cycles ago
        check_value($sformatf("mask_unit_output of result %0d", results_seen),
                    mask_unit_output, exp_e.data);
        check_value($sformatf("mask_reg_updated of result %0d", results_seen),
                    VLEN'(mask_reg_updated), VLEN'(exp_e.mask));
        results_seen++;
    endtask

    task automatic wait_outputs_zero();
        int waited;

        waited = 0;
        while ((mask_unit_output !== '0 || mask_reg_updated !== '0) && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= WAIT_LIMIT) begin
            $display("timeout: outputs never read zero after reset was released");
            $display("Verification failed");
            $fatal(1, "reset wait timed out");
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        expect_t zero_e;
        int      drained;

        seed          = 32'hec06_f465;
        results_seen  = 0;
        zero_e        = '0;
        drained       = 0;
        reset         = 1'b1;
        drive_idle();
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        wait_outputs_zero();

        // outputs stay zero until the first request lands
        for (int k = 0; k < LATENCY; k++) begin
            exp_q.push_back(zero_e);
        end
        for (int n = 0; n < NUM_REQ; n++) begin
            if (exp_q.size() >= LATENCY) begin
                check_outputs();
            end
            drive_random();             // back to back, every cycle
            @(negedge clk);
        end

        while (exp_q.size() > 0) begin
            if (drained >= WAIT_LIMIT) begin
                $display("timeout: results still pending after the last request");
                $display("Verification failed");
                $fatal(1, "drain timed out");
            end
            check_outputs();
            drive_idle();
            @(negedge clk);
            drained++;
        end

        $display("Verification passed");
        $finish;
    end

endmodule

/* all.f */
+incdir+verif
source/mask_unit_pkg.sv
source/element_classifier.sv
source/element_merge.sv
source/mask_logic_unit.sv
source/vector_mask_unit.sv
verif/tb_vector_mask_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the mask unit testbench with Verilator, run it, and judge the log.

cd "$(dirname "$0")" || exit 1

TOP=tb_vector_mask_unit
OBJ_DIR=obj_dir
BIN=sim_vector_mask_unit
LOG=sim.log

verilator --binary --timing --assert \
    -f all.f \
    --top-module "${TOP}" \
    --Mdir "${OBJ_DIR}" \
    -o "${BIN}"
if [ $? -ne 0 ]; then
    echo "run_sim: verilator build failed"
    exit 1
fi

"./${OBJ_DIR}/${BIN}" > "${LOG}" 2>&1
run_status=$?
cat "${LOG}"

if grep -q "Verification failed" "${LOG}"; then
    echo "run_sim: FAIL (see ${LOG})"
    exit 1
fi
if [ ${run_status} -ne 0 ]; then
    echo "run_sim: simulation exited with status ${run_status}"
    exit 1
fi

echo "run_sim: PASS"
exit 0
